// ==== project.f ====
+incdir+tests
source/ml_data_pkg.sv
source/ml_ctrl_pkg.sv
source/array_feed_if.sv
source/ml_pe.sv
source/ml_block.sv
source/array_feed.sv
source/result_align.sv
source/config_loader.sv
source/ml_engine_top.sv
tests/ml_engine_tb.sv

// ==== tests/ml_engine_model.svh ====
`ifndef ML_ENGINE_MODEL_SVH
`define ML_ENGINE_MODEL_SVH

// weights as loaded, row 0 at the top.
weight_t model_w [PE_H][PE_W];
logic [CFG_W-1:0] model_cfg;
sum_vec_t model_cas;

function automatic logic [CFG_W-1:0] make_cfg_word(input logic [PE_W*PE_H-1:0] pe_mask,
		input logic res_zero, input logic b_cas);
	logic [CFG_W-1:0] word;
	word = '0;
	word[CFG_RES_ZERO] = res_zero;
	word[CFG_B_CAS] = b_cas;
	for (int k = 0; k < PE_W * PE_H; k++) begin
		word[CFG_PE_BASE + k] = pe_mask[k];
	end
	return word;
endfunction

// one load strobe, every row moves up.
function automatic void model_load_row(input weight_vec_t row);
	for (int i = 0; i < PE_H - 1; i++) begin
		model_w[i] = model_w[i + 1];
	end
	for (int j = 0; j < PE_W; j++) begin
		model_w[PE_H - 1][j] = row[j];
	end
endfunction

function automatic sum_vec_t model_sums(input act_vec_t av);
	sum_vec_t sums;
	act_t av_i;
	for (int j = 0; j < PE_W; j++) begin
		sums[j] = model_cfg[CFG_RES_ZERO] ? acc_t'(0) : model_cas[j];
		for (int i = 0; i < PE_H; i++) begin
			av_i = av[i];
			if (model_cfg[CFG_PE_BASE + i * PE_W + j]) begin
				sums[j] = sums[j] + acc_t'(av_i) * acc_t'(model_w[i][j]);
			end
		end
	end
	return sums;
endfunction

`endif

// ==== tests/ml_engine_tb.sv ====
module ml_engine_tb import ml_data_pkg::*, ml_ctrl_pkg::*; ();
	localparam int PE_W = 3;
	localparam int PE_H = 4;
	localparam int CFG_W = 2 + PE_W * PE_H;
	localparam int LAT = PE_H + PE_W - 1;

	typedef act_t [PE_H-1:0] act_vec_t;
	typedef weight_t [PE_W-1:0] weight_vec_t;
	typedef acc_t [PE_W-1:0] sum_vec_t;

	logic clk = 1'b0;
	logic rst_n;
	logic cfg_load;
	logic [CFG_W-1:0] cfg_word;
	logic cfg_busy;
	logic a_en;
	act_vec_t a;
	logic b_en;
	weight_vec_t b;
	weight_vec_t b_cas_in;
	weight_vec_t b_cas_out;
	sum_vec_t res_cas_in;
	sum_vec_t res_out;
	logic res_valid;

	int seed = 32'h564d;
	int pending = 0;
	sum_vec_t exp_q [$];
	logic chk_q [$];

	`include "ml_engine_model.svh"

	always #5 clk = ~clk;

	ml_engine_top #(.PE_W(PE_W), .PE_H(PE_H)) i_ml_engine_top (
		.clk(clk),
		.rst_n(rst_n),
		.cfg_load(cfg_load),
		.cfg_word(cfg_word),
		.cfg_busy(cfg_busy),
		.a_en(a_en),
		.a(a),
		.b_en(b_en),
		.b(b),
		.b_cas_in(b_cas_in),
		.b_cas_out(b_cas_out),
		.res_cas_in(res_cas_in),
		.res_out(res_out),
		.res_valid(res_valid)
	);

	task automatic check_value(input string what, input longint got, input longint want);
		if (got !== want) begin
			$display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, want);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("timed out at %0t waiting for %s", $time, what);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	function automatic logic [PE_W*PE_H-1:0] random_mask();
		logic [PE_W*PE_H-1:0] mask;
		int r;
		for (int k = 0; k < PE_W * PE_H; k++) begin
			r = $random(seed);
			mask[k] = r[3];
		end
		return mask;
	endfunction

	task automatic load_config(input logic [CFG_W-1:0] word);
		int busy_cycles;
		int guard;
		@(posedge clk);
		cfg_word <= word;
		cfg_load <= 1'b1;
		@(posedge clk);
		cfg_load <= 1'b0;
		busy_cycles = 0;
		guard = 0;
		@(negedge clk);
		while (cfg_busy) begin
			busy_cycles++;
			guard++;
			if (guard > 4 * CFG_W) begin
				stop_on_timeout("cfg_busy to fall");
			end
			@(negedge clk);
		end
		check_value("cfg_busy cycles", busy_cycles, CFG_W);
		model_cfg = word;
	endtask

	// PE_H strobes fill the whole grid.
	task automatic load_matrix(input logic from_cas);
		weight_vec_t row;
		for (int r = 0; r < PE_H; r++) begin
			@(posedge clk);
			for (int j = 0; j < PE_W; j++) begin
				row[j] = weight_t'($random(seed));
			end
			b <= from_cas ? ~row : row;
			b_cas_in <= from_cas ? row : ~row;
			b_en <= 1'b1;
			model_load_row(row);
		end
		@(posedge clk);
		b_en <= 1'b0;
		@(negedge clk);
		for (int j = 0; j < PE_W; j++) begin
			check_value($sformatf("b_cas_out[%0d]", j), weight_t'(b_cas_out[j]),
				model_w[0][j]);
		end
	endtask

	task automatic run_vectors(input int count, input logic check, input logic stall);
		act_vec_t av;
		int idle;
		for (int n = 0; n < count; n++) begin
			idle = stall ? {$random(seed)} % 3 : 0;
			repeat (idle) begin
				@(posedge clk);
				a_en <= 1'b0;
			end
			@(posedge clk);
			for (int i = 0; i < PE_H; i++) begin
				av[i] = check ? act_t'($random(seed)) : act_t'(0);
			end
			a <= av;
			a_en <= 1'b1;
			exp_q.push_back(model_sums(av));
			chk_q.push_back(check);
			if (check) begin
				pending++;
			end
		end
		@(posedge clk);
		a_en <= 1'b0;
	endtask

	// pops one queued vector per valid step and skips flush vectors.
	initial begin : compare_results
		sum_vec_t want;
		logic want_check;
		logic stepped;
		forever begin
			@(posedge clk);
			stepped = a_en && rst_n;
			@(negedge clk);
			if (stepped && res_valid) begin
				if (exp_q.size() == 0) begin
					$display("a result came out with no vector left to expect it");
					$display("TEST FAILED");
					$fatal(1);
				end else begin
					want = exp_q.pop_front();
					want_check = chk_q.pop_front();
					if (want_check) begin
						for (int j = 0; j < PE_W; j++) begin
							check_value($sformatf("res_out[%0d]", j), res_out[j], want[j]);
						end
						pending--;
					end
				end
			end
		end
	end

	initial begin : stimulus
		sum_vec_t cas;
		int guard;
		rst_n = 1'b0;
		cfg_load = 1'b0;
		cfg_word = '0;
		a_en = 1'b0;
		a = '0;
		b_en = 1'b0;
		b = '0;
		b_cas_in = '0;
		res_cas_in = '0;
		model_cas = '0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		// cascade seeds stay on the input for the whole run.
		for (int j = 0; j < PE_W; j++) begin
			cas[j] = acc_t'($random(seed));
		end
		res_cas_in <= cas;
		model_cas = cas;
		@(negedge clk);
		check_value("res_valid after reset", res_valid, 0);
		check_value("cfg_busy after reset", cfg_busy, 0);

		// full grid with a zero seed.
		load_config(make_cfg_word('1, 1'b1, 1'b0));
		load_matrix(1'b0);
		run_vectors(24, 1'b1, 1'b0);
		run_vectors(LAT, 1'b0, 1'b0);

		load_config(make_cfg_word(random_mask(), 1'b1, 1'b0));
		run_vectors(24, 1'b1, 1'b0);
		run_vectors(LAT, 1'b0, 1'b0);

		// column seeds from the cascade input.
		load_config(make_cfg_word(random_mask(), 1'b0, 1'b0));
		run_vectors(24, 1'b1, 1'b0);
		run_vectors(LAT, 1'b0, 1'b0);

		// weights through b_cas_in with stalls.
		load_config(make_cfg_word(random_mask(), 1'b0, 1'b1));
		load_matrix(1'b1);
		run_vectors(40, 1'b1, 1'b1);
		run_vectors(LAT, 1'b0, 1'b0);

		guard = 0;
		while (pending > 0) begin
			guard++;
			if (guard > 4 * LAT) begin
				stop_on_timeout("the last results");
			end
			@(negedge clk);
		end
		$display("TEST OK");
		$finish;
	end
endmodule

// ==== source/ml_engine_top.sv ====
module ml_engine_top import ml_data_pkg::*; #(
	parameter int PE_W = 3,
	parameter int PE_H = 4,
	localparam int CFG_W = 2 + PE_W * PE_H
) (
	input logic clk,
	input logic rst_n,
	input logic cfg_load,
	input logic [CFG_W-1:0] cfg_word,
	output logic cfg_busy,
	input logic a_en,
	input act_t [PE_H-1:0] a,
	input logic b_en,
	input weight_t [PE_W-1:0] b,
	input weight_t [PE_W-1:0] b_cas_in,
	output weight_t [PE_W-1:0] b_cas_out,
	input acc_t [PE_W-1:0] res_cas_in,
	output acc_t [PE_W-1:0] res_out,
	output logic res_valid
);
	logic config_en;
	logic config_bit;
	acc_t [PE_W-1:0] col_sums;

	array_feed_if #(.PE_W(PE_W), .PE_H(PE_H)) feed_bus ();

	config_loader #(.PE_W(PE_W), .PE_H(PE_H)) i_config_loader (
		.clk(clk),
		.rst_n(rst_n),
		.cfg_load(cfg_load),
		.cfg_word(cfg_word),
		.cfg_busy(cfg_busy),
		.config_en(config_en),
		.config_bit(config_bit)
	);

	array_feed #(.PE_W(PE_W), .PE_H(PE_H)) i_array_feed (
		.clk(clk),
		.rst_n(rst_n),
		.a_en(a_en),
		.a(a),
		.b_en(b_en),
		.b(b),
		.feed(feed_bus.source)
	);

	// chain tail unused, single block.
	ml_block #(.PE_W(PE_W), .PE_H(PE_H)) i_ml_block (
		.clk(clk),
		.rst_n(rst_n),
		.feed(feed_bus.sink),
		.b_cas_in(b_cas_in),
		.b_cas_out(b_cas_out),
		.res_cas_in(res_cas_in),
		.res_out(col_sums),
		.config_en(config_en),
		.config_in(config_bit),
		.config_out()
	);

	result_align #(.PE_W(PE_W), .PE_H(PE_H)) i_result_align (
		.clk(clk),
		.rst_n(rst_n),
		.a_en(a_en),
		.sums(col_sums),
		.res_out(res_out),
		.res_valid(res_valid)
	);
endmodule

// ==== source/config_loader.sv ====
module config_loader import ml_ctrl_pkg::*; #(
	parameter int PE_W = 3,
	parameter int PE_H = 4,
	localparam int CFG_W = 2 + PE_W * PE_H
) (
	input logic clk,
	input logic rst_n,
	input logic cfg_load,
	input logic [CFG_W-1:0] cfg_word,
	output logic cfg_busy,
	output logic config_en,
	output logic config_bit
);
	localparam int CNT_W = $clog2(CFG_W);

	loader_state_t state;
	logic [CNT_W-1:0] cnt;
	logic [CFG_W-1:0] shreg;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (cfg_load) begin
						state <= SHIFT;
						cnt <= '0;
					end
				end
				SHIFT: begin
					cnt <= cnt + 1'b1;
					if (cnt == CNT_W'(CFG_W - 1)) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// top bit leaves first, so bit k ends in stage k.
	always_ff @(posedge clk) begin
		if (state == IDLE && cfg_load) begin
			shreg <= cfg_word;
		end else if (state == SHIFT) begin
			shreg <= shreg << 1;
		end
	end

	assign cfg_busy = (state == SHIFT);
	assign config_en = (state == SHIFT);
	assign config_bit = shreg[CFG_W-1];
endmodule

// ==== source/result_align.sv ====
module result_align import ml_data_pkg::*; #(
	parameter int PE_W = 3,
	parameter int PE_H = 4
) (
	input logic clk,
	input logic rst_n,
	input logic a_en,
	input acc_t [PE_W-1:0] sums,
	output acc_t [PE_W-1:0] res_out,
	output logic res_valid
);
	localparam int LAT = PE_H + PE_W - 1;
	localparam int CNT_W = $clog2(LAT + 1);

	logic [CNT_W-1:0] steps;

	for (genvar j = 0; j < PE_W; j++) begin : g_col
		// last stage is the output register.
		acc_t dly [PE_W-j];

		always_ff @(posedge clk) begin
			if (a_en) begin
				dly[0] <= sums[j];
				for (int k = 1; k < PE_W - j; k++) begin
					dly[k] <= dly[k-1];
				end
			end
		end

		assign res_out[j] = dly[PE_W-j-1];
	end

	// first result lands on the step after LAT steps.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			steps <= '0;
			res_valid <= 1'b0;
		end else if (a_en) begin
			if (steps == CNT_W'(LAT)) begin
				res_valid <= 1'b1;
			end else begin
				steps <= steps + 1'b1;
			end
		end
	end
endmodule

// ==== source/array_feed.sv ====
module array_feed import ml_data_pkg::*; #(
	parameter int PE_W = 3,
	parameter int PE_H = 4
) (
	input logic clk,
	input logic rst_n,
	input logic a_en,
	input act_t [PE_H-1:0] a,
	input logic b_en,
	input weight_t [PE_W-1:0] b,
	array_feed_if.source feed
);
	for (genvar i = 0; i < PE_H; i++) begin : g_row
		if (i == 0) begin : g_direct
			assign feed.a[i] = a[i];
		end else begin : g_delay
			// i stages, so row i meets the sum of row i-1.
			act_t dly [i];

			always_ff @(posedge clk) begin
				if (!rst_n) begin
					for (int k = 0; k < i; k++) begin
						dly[k] <= '0;
					end
				end else if (a_en) begin
					dly[0] <= a[i];
					for (int k = 1; k < i; k++) begin
						dly[k] <= dly[k-1];
					end
				end
			end

			assign feed.a[i] = dly[i-1];
		end
	end

	assign feed.a_en = a_en;
	assign feed.b = b;
	assign feed.b_en = b_en;
endmodule

// ==== source/ml_block.sv ====
module ml_block import ml_data_pkg::*, ml_ctrl_pkg::*; #(
	parameter int PE_W = 3,
	parameter int PE_H = 4
) (
	input logic clk,
	input logic rst_n,
	array_feed_if.sink feed,
	input weight_t [PE_W-1:0] b_cas_in,
	output weight_t [PE_W-1:0] b_cas_out,
	input acc_t [PE_W-1:0] res_cas_in,
	output acc_t [PE_W-1:0] res_out,
	input logic config_en,
	input logic config_in,
	output logic config_out
);
	localparam int CFG_W = CFG_PE_BASE + PE_W * PE_H;

	logic [CFG_B_CAS:CFG_RES_ZERO] blk_cfg;
	logic chain [CFG_PE_BASE:CFG_W];

	// activations move right, weights up, sums down.
	act_t a_w [PE_H][PE_W+1];
	weight_t b_w [PE_H+1][PE_W];
	acc_t s_w [PE_H+1][PE_W];

	// block bits are the first two chain stages.
	always_ff @(posedge clk) begin
		if (config_en) begin
			blk_cfg[CFG_RES_ZERO] <= config_in;
			blk_cfg[CFG_B_CAS] <= blk_cfg[CFG_RES_ZERO];
		end
	end

	assign chain[CFG_PE_BASE] = blk_cfg[CFG_B_CAS];
	assign config_out = chain[CFG_W];

	for (genvar j = 0; j < PE_W; j++) begin : g_col
		// bottom row weight source.
		assign b_w[PE_H][j] = blk_cfg[CFG_B_CAS] ? b_cas_in[j] : feed.b[j];
		// column seed at the top row.
		assign s_w[0][j] = blk_cfg[CFG_RES_ZERO] ? '0 : res_cas_in[j];
		assign b_cas_out[j] = b_w[0][j];
		assign res_out[j] = s_w[PE_H][j];
	end

	for (genvar i = 0; i < PE_H; i++) begin : g_row
		assign a_w[i][0] = feed.a[i];

		for (genvar j = 0; j < PE_W; j++) begin : g_pe
			ml_pe i_pe (
				.clk(clk),
				.rst_n(rst_n),
				.a_en(feed.a_en),
				.a(a_w[i][j]),
				.a_out(a_w[i][j+1]),
				.b_en(feed.b_en),
				.b(b_w[i+1][j]),
				.b_out(b_w[i][j]),
				.res_in(s_w[i][j]),
				.res_out(s_w[i+1][j]),
				.config_en(config_en),
				.config_in(chain[CFG_PE_BASE + i * PE_W + j]),
				.config_out(chain[CFG_PE_BASE + i * PE_W + j + 1])
			);
		end
	end
endmodule

// ==== source/ml_pe.sv ====
module ml_pe import ml_data_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic a_en,
	input act_t a,
	output act_t a_out,
	input logic b_en,
	input weight_t b,
	output weight_t b_out,
	input acc_t res_in,
	output acc_t res_out,
	input logic config_en,
	input logic config_in,
	output logic config_out
);
	weight_t w;
	logic pe_on;
	acc_t prod;

	// pruned weight adds zero.
	assign prod = pe_on ? acc_t'(a) * acc_t'(w) : '0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			a_out <= '0;
			res_out <= '0;
		end else if (a_en) begin
			a_out <= a;
			res_out <= res_in + prod;
		end
	end

	// weight moves up one row per load strobe.
	always_ff @(posedge clk) begin
		if (b_en) begin
			w <= b;
		end
	end

	always_ff @(posedge clk) begin
		if (config_en) begin
			pe_on <= config_in;
		end
	end

	assign b_out = w;
	assign config_out = pe_on;
endmodule

// ==== source/array_feed_if.sv ====
interface array_feed_if import ml_data_pkg::*; #(
	parameter int PE_W = 3,
	parameter int PE_H = 4
) ();
	// row i lags row 0 by i steps.
	act_t [PE_H-1:0] a;
	logic a_en;
	weight_t [PE_W-1:0] b;
	logic b_en;

	modport source (
		output a,
		output a_en,
		output b,
		output b_en
	);

	modport sink (
		input a,
		input a_en,
		input b,
		input b_en
	);
endinterface

// ==== source/ml_ctrl_pkg.sv ====
package ml_ctrl_pkg;

	// bit positions in the configuration word.
	// column sums start from zero instead of res_cas_in.
	localparam int CFG_RES_ZERO = 0;
	// bottom row loads from b_cas_in instead of b.
	localparam int CFG_B_CAS = 1;
	// PE(i,j) enable sits at CFG_PE_BASE + i*PE_W + j.
	localparam int CFG_PE_BASE = 2;

	// serial config loader states.
	typedef enum logic {
		IDLE,
		SHIFT
	} loader_state_t;

endpackage

// ==== source/ml_data_pkg.sv ====
package ml_data_pkg;

	// signed activation, one per grid row.
	typedef logic signed [7:0] act_t;

	// signed stationary weight, one per grid column.
	typedef logic signed [7:0] weight_t;

	// column partial sum. products and sums wrap at this width.
	typedef logic signed [31:0] acc_t;

endpackage
